// File: logic/mipsPkg.sv
package mipsPkg;

	typedef logic [31:0] word;
	typedef logic [4:0] regAddr;

	// major opcode field, instr[31:26]
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJ       = 6'h02,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddiu   = 6'h09,
		opAndi    = 6'h0c,
		opOri     = 6'h0d,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeT;

	// function field of SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnXor  = 6'h26,
		fnSlt  = 6'h2a
	} functT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluLui
	} aluOpT;

	// all zero is a no-op
	typedef struct packed {
		logic  regWrite;
		logic  memToReg;
		logic  memWrite;
		logic  aluSrcImm;
		logic  zeroExtend;
		logic  regDstRd;
		logic  branch;
		logic  branchNe;
		logic  jump;
		aluOpT aluOp;
	} ctrlT;

	// decode -> execute
	typedef struct packed {
		ctrlT   ctrl;
		word    srcA;
		word    srcB;
		word    imm;
		regAddr rs;
		regAddr rt;
		regAddr rd;
	} exStageT;

	// execute -> memory
	typedef struct packed {
		logic   regWrite;
		logic   memToReg;
		logic   memWrite;
		word    aluOut;
		word    storeData;
		regAddr dest;
	} memStageT;

	// memory -> writeback
	typedef struct packed {
		logic   regWrite;
		logic   memToReg;
		word    aluOut;
		word    loadData;
		regAddr dest;
	} wbStageT;

	typedef enum logic [1:0] {
		fwdReg = 2'd0,
		fwdMem = 2'd1,
		fwdWb  = 2'd2
	} fwdSelT;

endpackage

// File: logic/controlDecoder.sv
module controlDecoder import mipsPkg::*; (
	input  opcodeT opcode,
	input  functT  funct,
	output ctrlT   ctrl
);

	always_comb begin
		ctrl = '0;
		case (opcode)
			opSpecial: begin
				// only the listed R-type ops write back, others stay a no-op
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				case (funct)
					fnAddu: ctrl.aluOp = aluAdd;
					fnSubu: ctrl.aluOp = aluSub;
					fnAnd:  ctrl.aluOp = aluAnd;
					fnOr:   ctrl.aluOp = aluOr;
					fnXor:  ctrl.aluOp = aluXor;
					fnSlt:  ctrl.aluOp = aluSlt;
					default: ctrl = '0;
				endcase
			end
			opAddiu: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = aluAdd;
			end
			opAndi, opOri: begin
				ctrl.regWrite   = 1'b1;
				ctrl.aluSrcImm  = 1'b1;
				ctrl.zeroExtend = 1'b1;
				ctrl.aluOp      = (opcode == opAndi) ? aluAnd : aluOr;
			end
			opLui: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp     = aluLui;
			end
			opLw: begin
				ctrl.regWrite  = 1'b1;
				ctrl.memToReg  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opSw: begin
				ctrl.memWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opBeq, opBne: begin
				ctrl.branch   = 1'b1;
				ctrl.branchNe = (opcode == opBne);
			end
			opJ: ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

// File: logic/regFile.sv
module regFile import mipsPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	input  logic   writeEn,
	input  regAddr writeAddr,
	input  word    writeData,
	input  regAddr readAddrA,
	input  regAddr readAddrB,
	output word    readA,
	output word    readB
);

	// r0 has no storage
	word regs [1:31];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < 32; i++) regs[i] <= '0;
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// same-cycle write goes straight through to the reader
	function automatic word readPort(regAddr addr);
		if (addr == '0) return '0;
		if (writeEn && addr == writeAddr) return writeData;
		return regs[addr];
	endfunction

	always_comb begin
		readA = readPort(readAddrA);
		readB = readPort(readAddrB);
	end

endmodule

// File: logic/alu.sv
module alu import mipsPkg::*; (
	input  word   a,
	input  word   b,
	input  aluOpT op,
	output word   result
);

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr:  result = a | b;
			aluXor: result = a ^ b;
			// signed compare, result is 0 or 1
			aluSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			// immediate lands in the upper half
			aluLui: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

endmodule

// File: logic/hazardUnit.sv
module hazardUnit import mipsPkg::*; (
	input  regAddr rsD,
	input  regAddr rtD,
	input  regAddr rsE,
	input  regAddr rtE,
	input  regAddr destE,
	input  regAddr destM,
	input  regAddr destW,
	input  logic   regWriteE,
	input  logic   regWriteM,
	input  logic   regWriteW,
	input  logic   memToRegE,
	input  logic   memToRegM,
	input  logic   branchD,
	output logic   fwdDecA,
	output logic   fwdDecB,
	output fwdSelT fwdExA,
	output fwdSelT fwdExB,
	output logic   stallF,
	output logic   stallD,
	output logic   flushE
);

	logic loadUse;
	logic branchStall;

	// memory stage wins over writeback
	function automatic fwdSelT exSel(regAddr src);
		if (src != '0 && regWriteM && src == destM) return fwdMem;
		if (src != '0 && regWriteW && src == destW) return fwdWb;
		return fwdReg;
	endfunction

	always_comb begin
		fwdExA = exSel(rsE);
		fwdExB = exSel(rtE);
	end

	// branch compare only takes ALU results from memory
	assign fwdDecA = rsD != '0 && regWriteM && rsD == destM;
	assign fwdDecB = rtD != '0 && regWriteM && rtD == destM;

	assign loadUse = memToRegE && (rsD == destE || rtD == destE);

	// operand still in execute, or a load still in memory
	assign branchStall = branchD &&
		((regWriteE && destE != '0 && (rsD == destE || rtD == destE)) ||
		(memToRegM && destM != '0 && (rsD == destM || rtD == destM)));

	assign stallF = loadUse || branchStall;
	assign stallD = stallF;
	assign flushE = stallF;

endmodule

// File: logic/datapath.sv
module datapath import mipsPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	input  word    instr,
	output word    pc,
	input  ctrlT   ctrl,
	output opcodeT opcode,
	output functT  funct,
	output regAddr rsD,
	output regAddr rtD,
	output regAddr rsE,
	output regAddr rtE,
	output regAddr destE,
	output regAddr destM,
	output regAddr destW,
	output logic   regWriteE,
	output logic   regWriteM,
	output logic   regWriteW,
	output logic   memToRegE,
	output logic   memToRegM,
	output logic   branchD,
	input  logic   fwdDecA,
	input  logic   fwdDecB,
	input  fwdSelT fwdExA,
	input  fwdSelT fwdExB,
	input  logic   stallF,
	input  logic   stallD,
	input  logic   flushE,
	output logic   memWrite,
	output word    dataAddr,
	output word    writeData,
	input  word    readData
);

	word instrD;
	word pcPlus4D;
	word pcNext;
	word immD;
	word rfA;
	word rfB;
	word cmpA;
	word cmpB;
	logic takenD;
	exStageT exQ;
	memStageT memQ;
	wbStageT wbQ;
	word srcAE;
	word srcBE;
	word aluOutE;
	word resultW;

	// ========================================================================
	// fetch
	// ========================================================================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc       <= '0;
			instrD   <= '0;
			pcPlus4D <= '0;
		end else begin
			if (!stallF) pc <= pcNext;
			if (!stallD) begin
				instrD   <= instr;
				pcPlus4D <= pc + 32'd4;
			end
		end
	end

	// ========================================================================
	// decode
	// ========================================================================

	assign opcode  = opcodeT'(instrD[31:26]);
	assign funct   = functT'(instrD[5:0]);
	assign rsD     = instrD[25:21];
	assign rtD     = instrD[20:16];
	assign branchD = ctrl.branch;

	assign immD = ctrl.zeroExtend ? {16'h0000, instrD[15:0]}
		: {{16{instrD[15]}}, instrD[15:0]};

	regFile regs (
		.clk       (clk),
		.arstN     (arstN),
		.writeEn   (wbQ.regWrite),
		.writeAddr (wbQ.dest),
		.writeData (resultW),
		.readAddrA (rsD),
		.readAddrB (rtD),
		.readA     (rfA),
		.readB     (rfB)
	);

	// early branch compare
	assign cmpA   = fwdDecA ? memQ.aluOut : rfA;
	assign cmpB   = fwdDecB ? memQ.aluOut : rfB;
	assign takenD = ctrl.branch && ((cmpA == cmpB) != ctrl.branchNe);

	// delay slot is already in fetch, so the target goes straight to pc
	always_comb begin
		if (ctrl.jump)
			pcNext = {pcPlus4D[31:28], instrD[25:0], 2'b00};
		else if (takenD)
			pcNext = pcPlus4D + {immD[29:0], 2'b00};
		else
			pcNext = pc + 32'd4;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) exQ <= '0;
		else if (flushE) exQ <= '0;
		else exQ <= '{ctrl: ctrl, srcA: rfA, srcB: rfB, imm: immD,
			rs: rsD, rt: rtD, rd: instrD[15:11]};
	end

	// ========================================================================
	// execute
	// ========================================================================

	function automatic word fwdPick(fwdSelT sel, word regVal);
		case (sel)
			fwdMem: return memQ.aluOut;
			fwdWb:  return resultW;
			default: return regVal;
		endcase
	endfunction

	assign rsE       = exQ.rs;
	assign rtE       = exQ.rt;
	assign regWriteE = exQ.ctrl.regWrite;
	assign memToRegE = exQ.ctrl.memToReg;
	assign destE     = exQ.ctrl.regDstRd ? exQ.rd : exQ.rt;

	always_comb begin
		srcAE = fwdPick(fwdExA, exQ.srcA);
		srcBE = fwdPick(fwdExB, exQ.srcB);
	end

	alu exAlu (
		.a      (srcAE),
		.b      (exQ.ctrl.aluSrcImm ? exQ.imm : srcBE),
		.op     (exQ.ctrl.aluOp),
		.result (aluOutE)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) memQ <= '0;
		else memQ <= '{regWrite: exQ.ctrl.regWrite, memToReg: exQ.ctrl.memToReg,
			memWrite: exQ.ctrl.memWrite, aluOut: aluOutE, storeData: srcBE,
			dest: destE};
	end

	// ========================================================================
	// memory and writeback
	// ========================================================================

	assign destM     = memQ.dest;
	assign regWriteM = memQ.regWrite;
	assign memToRegM = memQ.memToReg;
	assign memWrite  = memQ.memWrite;
	assign dataAddr  = memQ.aluOut;
	assign writeData = memQ.storeData;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) wbQ <= '0;
		else wbQ <= '{regWrite: memQ.regWrite, memToReg: memQ.memToReg,
			aluOut: memQ.aluOut, loadData: readData, dest: memQ.dest};
	end

	assign destW     = wbQ.dest;
	assign regWriteW = wbQ.regWrite;
	assign resultW   = wbQ.memToReg ? wbQ.loadData : wbQ.aluOut;

endmodule

// File: logic/dataRam.sv
module dataRam import mipsPkg::*; #(
	parameter int ramWords = 64
) (
	input  logic clk,
	input  logic writeEn,
	input  word  addr,
	input  word  writeData,
	output word  readData
);

	localparam int idxBits = $clog2(ramWords);

	word mem [ramWords];
	logic [idxBits-1:0] index;

	// byte address to word index, wraps at the depth
	assign index = addr[idxBits+1:2];

	always_ff @(posedge clk) begin
		if (writeEn) mem[index] <= writeData;
	end

	assign readData = mem[index];

endmodule

// File: logic/mipsCore.sv
module mipsCore import mipsPkg::*; #(
	parameter int ramWords = 64
) (
	input  logic clk,
	input  logic arstN,
	input  word  instr,
	output word  pc,
	output logic memWrite,
	output word  dataAddr,
	output word  writeData
);

	ctrlT ctrl;
	opcodeT opcode;
	functT funct;
	regAddr rsD, rtD, rsE, rtE, destE, destM, destW;
	logic regWriteE, regWriteM, regWriteW, memToRegE, memToRegM, branchD;
	logic fwdDecA, fwdDecB, stallF, stallD, flushE;
	fwdSelT fwdExA, fwdExB;
	word readData;

	controlDecoder decoder (.opcode(opcode), .funct(funct), .ctrl(ctrl));

	hazardUnit hazard (.*);

	datapath dp (.*);

	dataRam #(.ramWords(ramWords)) ram (
		.clk       (clk),
		.writeEn   (memWrite),
		.addr      (dataAddr),
		.writeData (writeData),
		.readData  (readData)
	);

endmodule

// File: verif/coreTb.sv
module coreTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int numProgs    = 6;
	localparam int resetCycles = 16;
	localparam int clearWords  = 64;
	localparam int bodyLen     = 48;
	localparam int dumpStart   = clearWords + bodyLen;
	localparam int loopIdx     = dumpStart + 7;
	localparam int drainCycles = 6;
	// clearing stores never stall, every later instruction takes at most three cycles
	localparam int progCycles  = resetCycles + clearWords + (bodyLen + 9) * 3 + drainCycles + 4;
	localparam int cycleLimit  = numProgs * progCycles;
	localparam logic [31:0] loopAddr = 32'(loopIdx * 4);

	logic        clk;
	logic        arstN;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        memWrite;
	logic [31:0] dataAddr;
	logic [31:0] writeData;

	logic [31:0] rom [128];
	logic [15:0] lfsr;
	logic [31:0] mRegs [32];
	logic [31:0] mMem [64];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] gotData [$];
	int expIdx;
	int errors;
	int checked;
	int cycles;
	int progNum;

	mipsCore #(.ramWords(64)) dut0 (
		.clk       (clk),
		.arstN     (arstN),
		.instr     (instr),
		.pc        (pc),
		.memWrite  (memWrite),
		.dataAddr  (dataAddr),
		.writeData (writeData)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ========================================================================
	// random source and instruction encoding
	// ========================================================================

	// taps 16, 14, 13, 11
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] takeBits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[30:0], lfsrBit()};
		return v;
	endfunction

	// r1 to r7
	function automatic logic [4:0] pickReg();
		return 5'(takeBits(3) % 7 + 1);
	endfunction

	function automatic logic [5:0] pickFunct();
		case (takeBits(3) % 6)
			0: return 6'h21;
			1: return 6'h23;
			2: return 6'h24;
			3: return 6'h25;
			4: return 6'h26;
			default: return 6'h2a;
		endcase
	endfunction

	function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
		errors++;
		$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
	endtask

	// clear RAM, random body, register dump, then a J to itself
	task automatic buildProgram();
		logic [4:0] prevDest;
		logic [4:0] src;
		logic [4:0] dst;
		logic [3:0] kind;
		logic       slot;
		int         off;
		prevDest = 5'd1;
		slot = 1'b0;
		for (int i = 0; i < 128; i++) rom[i] = '0;
		for (int i = 0; i < clearWords; i++) rom[i] = iType(6'h2b, 5'd0, 5'd0, 16'(i * 4));
		for (int i = clearWords; i < dumpStart; i++) begin
			kind = 4'(takeBits(4));
			src = takeBits(1) != 0 ? prevDest : pickReg();
			dst = pickReg();
			off = int'(takeBits(2)) + 1;
			// no transfer in a delay slot, and targets stay inside the body
			if (kind >= 4'd13 && (slot || i + 1 + off >= dumpStart)) kind = kind - 4'd13;
			slot = kind >= 4'd13;
			case (kind)
				4'd6:  rom[i] = iType(6'h09, src, dst, 16'(takeBits(16)));
				4'd7:  rom[i] = iType(6'h0c, src, dst, 16'(takeBits(16)));
				4'd8:  rom[i] = iType(6'h0d, src, dst, 16'(takeBits(16)));
				4'd9:  rom[i] = iType(6'h0f, 5'd0, dst, 16'(takeBits(16)));
				4'd10, 4'd11: rom[i] = iType(6'h23, 5'd0, dst, 16'(takeBits(6) << 2));
				4'd12: rom[i] = iType(6'h2b, 5'd0, src, 16'(takeBits(6) << 2));
				4'd13: rom[i] = iType(6'h04, src, 5'(takeBits(3)), 16'(off));
				4'd14: rom[i] = iType(6'h05, src, 5'(takeBits(3)), 16'(off));
				4'd15: rom[i] = {6'h02, 26'(i + 1 + off)};
				default: rom[i] = {6'h00, src, pickReg(), dst, 5'd0, pickFunct()};
			endcase
			if (kind <= 4'd11) prevDest = dst;
		end
		for (int k = 1; k <= 7; k++)
			rom[dumpStart + k - 1] = iType(6'h2b, 5'd0, 5'(k), 16'(k * 4));
		rom[loopIdx] = {6'h02, 26'(loopIdx)};
		rom[loopIdx + 1] = '0;
	endtask

	// ========================================================================
	// architectural model, delay slot included
	// ========================================================================

	task automatic runModel();
		logic [31:0] ins;
		logic [31:0] pcM;
		logic [31:0] npc;
		logic [31:0] after;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] addr;
		logic [4:0]  rt;
		int          steps;
		for (int i = 0; i < 32; i++) mRegs[i] = '0;
		for (int i = 0; i < 64; i++) mMem[i] = '0;
		expAddr.delete();
		expData.delete();
		pcM = '0;
		npc = 32'd4;
		steps = 0;
		while (steps < 1000 && pcM != loopAddr) begin
			ins = rom[pcM[8:2]];
			a = mRegs[ins[25:21]];
			b = mRegs[ins[20:16]];
			rt = ins[20:16];
			se = {{16{ins[15]}}, ins[15:0]};
			addr = a + se;
			after = npc + 32'd4;
			case (ins[31:26])
				6'h00: begin
					case (ins[5:0])
						6'h21: mRegs[ins[15:11]] = a + b;
						6'h23: mRegs[ins[15:11]] = a - b;
						6'h24: mRegs[ins[15:11]] = a & b;
						6'h25: mRegs[ins[15:11]] = a | b;
						6'h26: mRegs[ins[15:11]] = a ^ b;
						6'h2a: mRegs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: ;
					endcase
				end
				6'h09: mRegs[rt] = addr;
				6'h0c: mRegs[rt] = a & {16'h0000, ins[15:0]};
				6'h0d: mRegs[rt] = a | {16'h0000, ins[15:0]};
				6'h0f: mRegs[rt] = {ins[15:0], 16'h0000};
				6'h23: mRegs[rt] = mMem[addr[7:2]];
				6'h2b: begin
					mMem[addr[7:2]] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
				end
				6'h04: if (a == b) after = npc + (se << 2);
				6'h05: if (a != b) after = npc + (se << 2);
				6'h02: after = {npc[31:28], ins[25:0], 2'b00};
				default: ;
			endcase
			mRegs[0] = '0;
			pcM = npc;
			npc = after;
			steps++;
		end
	endtask

	// ========================================================================
	// store monitor, instruction ROM and cycle limit
	// ========================================================================

	always @(negedge clk) begin
		if (memWrite) begin
			if (expIdx >= expAddr.size()) begin
				errors++;
				$display("prog%0d: store of %h to %h after all %0d model stores were seen",
					progNum, writeData, dataAddr, expAddr.size());
			end else begin
				if (dataAddr !== expAddr[expIdx])
					reportMismatch($sformatf("prog%0d store%0d addr", progNum, expIdx),
						expAddr[expIdx], dataAddr);
				if (writeData !== expData[expIdx])
					reportMismatch($sformatf("prog%0d store%0d data", progNum, expIdx),
						expData[expIdx], writeData);
				expIdx++;
				checked++;
			end
			gotData.push_back(writeData);
		end
		instr = rom[pc[8:2]];
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout after %0d cycles in program %0d", cycles, progNum);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic runProgram(int p);
		@(negedge clk);
		arstN = 1'b0;
		progNum = p;
		buildProgram();
		runModel();
		expIdx = 0;
		gotData.delete();
		repeat (resetCycles - 1) @(negedge clk);
		if (pc !== '0) begin
			errors++;
			$display("prog%0d: pc is %h in reset instead of 0", p, pc);
		end
		if (memWrite !== 1'b0) begin
			errors++;
			$display("prog%0d: memWrite is high while the core is in reset", p);
		end
		@(negedge clk);
		arstN = 1'b1;
		// final loop reached, then let the last dump stores leave the pipeline
		while (pc !== loopAddr) @(negedge clk);
		repeat (drainCycles) @(negedge clk);
		if (gotData.size() != expAddr.size())
			reportMismatch($sformatf("prog%0d store count", p), 32'(expAddr.size()),
				32'(gotData.size()));
		for (int k = 1; k <= 7; k++) begin
			if (gotData.size() >= 7 && gotData[gotData.size() - 8 + k] !== mRegs[k])
				reportMismatch($sformatf("prog%0d dump r%0d", p, k), mRegs[k],
					gotData[gotData.size() - 8 + k]);
		end
	endtask

	initial begin
		arstN = 1'b0;
		instr = '0;
		lfsr = 16'd90;
		errors = 0;
		checked = 0;
		cycles = 0;
		progNum = 0;
		expIdx = 0;
		for (int i = 0; i < 128; i++) rom[i] = '0;
		for (int p = 0; p < numProgs; p++) runProgram(p);
		$display("programs %0d, stores checked %0d, errors %0d", numProgs, checked, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: all.f
logic/mipsPkg.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/hazardUnit.sv
logic/datapath.sv
logic/dataRam.sv
logic/mipsCore.sv
verif/coreTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module coreTb -f all.f -o coreSim &&
./obj_dir/coreSim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
